// File: design/soqpsk_pkg.sv
/*
 * SOQPSK transmitter package
 * phase word, alpha and output mode types, modulation constants
 */

package soqpsk_pkg;

	//**********************************************************************
	// phase word
	//**********************************************************************
	localparam int PHASE_W = 14;

	typedef logic [PHASE_W-1:0] phase_t; // full turn = 2**PHASE_W

	localparam phase_t QUARTER_TURN = phase_t'(4096); // pi/2

	// top NCO bits that make up one symbol ramp, full ramp = pi/2
	localparam int RAMP_W = 12;

	//**********************************************************************
	// symbol decisions and modes
	//**********************************************************************
	typedef enum logic [1:0]
	{
		ALPHA_ZERO = 2'd0,
		ALPHA_POS  = 2'd1,
		ALPHA_NEG  = 2'd3
	} alpha_t;

	typedef enum logic [1:0]
	{
		MODE_SOQPSK  = 2'd0,
		MODE_CARRIER = 2'd1, // unmodulated carrier, zero phase
		MODE_TEST    = 2'd2  // raw NCO phase
	} mode_t;

	// RNRZ-L taps, stages counted from 1
	localparam int SCRAM_TAP_A = 14;
	localparam int SCRAM_TAP_B = 15; // also the register length

	localparam logic FILL_BIT = 1'b1; // sent when the source runs dry

endpackage

// File: design/symbol_nco.sv
/*
 * Symbol rate NCO
 * accumulates the frequency word and flags each wrap as a symbol strobe
 */

`timescale 1ns/1ns

module symbol_nco
#(
	parameter int NCO_W = 32
)
(
	input  logic             clk,
	input  logic             rst,
	input  logic [NCO_W-1:0] freq_word,
	output logic [NCO_W-1:0] nco_phase,
	output logic             sym_strobe
);

	logic [NCO_W:0] sum; // one extra bit catches the wrap

	assign sum = {1'b0, nco_phase} + {1'b0, freq_word};

	// strobe lines up with the first wrapped phase value
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			nco_phase  <= '0;
			sym_strobe <= 1'b0;
		end
		else
		begin
			nco_phase  <= sum[NCO_W-1:0];
			sym_strobe <= sum[NCO_W];
		end
	end

endmodule

// File: design/bit_intake.sv
/*
 * Source bit intake
 * four-phase req/ack capture into a one bit buffer, fill bit on underrun,
 * data polarity and RNRZ-L scrambling, one bit out per symbol strobe
 */

`timescale 1ns/1ns

module bit_intake
(
	input  logic clk,
	input  logic rst,
	input  logic sym_strobe,
	input  logic src_req,
	input  logic src_data,
	input  logic dat_pol,
	input  logic rand_en,
	output logic src_ack,
	output logic tx_bit,
	output logic bit_valid,
	output logic underrun
);

	import soqpsk_pkg::*;

	logic                   buf_full;
	logic                   buf_bit;
	logic                   capture;
	logic                   raw_bit;
	logic                   pol_bit;
	logic                   scram_bit;
	logic [SCRAM_TAP_B-1:0] scram; // stage 1 in bit 0

	//**********************************************************************
	// handshake
	//**********************************************************************
	// take a new bit only with an empty buffer and ack already dropped
	assign capture = src_req & ~src_ack & ~buf_full;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			src_ack  <= 1'b0;
			buf_full <= 1'b0;
		end
		else
		begin
			if (capture)
				src_ack <= 1'b1;
			else if (!src_req)
				src_ack <= 1'b0; // source let go, close the cycle

			if (sym_strobe)
				buf_full <= 1'b0;
			if (capture)
				buf_full <= 1'b1; // capture only happens when empty
		end
	end

	always_ff @(posedge clk)
	begin
		if (capture)
			buf_bit <= src_data;
	end

	//**********************************************************************
	// polarity and scrambler
	//**********************************************************************
	assign raw_bit   = buf_full ? buf_bit : FILL_BIT;
	assign pol_bit   = raw_bit ^ dat_pol;
	assign scram_bit = pol_bit ^ scram[SCRAM_TAP_A-1] ^ scram[SCRAM_TAP_B-1];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			scram     <= '0;
			bit_valid <= 1'b0;
			underrun  <= 1'b0;
		end
		else
		begin
			bit_valid <= sym_strobe;
			underrun  <= sym_strobe & ~buf_full;
			if (sym_strobe && rand_en)
				scram <= {scram[SCRAM_TAP_B-2:0], scram_bit}; // self-sync, feed back output
		end
	end

	always_ff @(posedge clk)
	begin
		if (sym_strobe)
			tx_bit <= rand_en ? scram_bit : pol_bit;
	end

endmodule

// File: design/soqpsk_precoder.sv
/*
 * SOQPSK precoder
 * alternate I/Q bit updates, optional differential encoding, alpha decision
 */

`timescale 1ns/1ns

module soqpsk_precoder
(
	input  logic                clk,
	input  logic                rst,
	input  logic                tx_bit,
	input  logic                bit_valid,
	input  logic                diff_en,
	output soqpsk_pkg::alpha_t  alpha,
	output logic                alpha_valid
);

	import soqpsk_pkg::*;

	logic   flip; // 0 writes I, 1 writes Q
	logic   i0, i1, i2;
	logic   q0, q1, q2;
	alpha_t alpha_next;

	// decision from the state before this bit lands
	always_comb
	begin
		alpha_next = ALPHA_ZERO;
		if (!flip)
		begin
			if (q0 != q2)
				alpha_next = (q0 == i1) ? ALPHA_POS : ALPHA_NEG;
		end
		else if (i0 != i2)
		begin
			alpha_next = (i0 != q1) ? ALPHA_POS : ALPHA_NEG;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			flip        <= 1'b0;
			i0          <= 1'b1;
			i1          <= 1'b1;
			i2          <= 1'b1;
			q0          <= 1'b1;
			q1          <= 1'b1;
			q2          <= 1'b1;
			alpha       <= ALPHA_ZERO;
			alpha_valid <= 1'b0;
		end
		else
		begin
			alpha_valid <= bit_valid;
			if (bit_valid)
			begin
				flip <= ~flip;
				i1   <= i0; // history moves every symbol
				i2   <= i1;
				q1   <= q0;
				q2   <= q1;
				if (!flip)
					i0 <= diff_en ? (tx_bit ^ ~q0) : tx_bit;
				else
					q0 <= diff_en ? (tx_bit ^ i0) : tx_bit;
				alpha <= alpha_next;
			end
		end
	end

endmodule

// File: design/phase_modulator.sv
/*
 * Phase modulator
 * rolls finished symbol steps modulo a full turn, adds the signed symbol
 * ramp and picks the output phase by mode
 */

`timescale 1ns/1ns

module phase_modulator
#(
	parameter int NCO_W = 32
)
(
	input  logic                clk,
	input  logic                rst,
	input  logic [NCO_W-1:0]    nco_phase,
	input  soqpsk_pkg::alpha_t  alpha,
	input  logic                alpha_valid,
	input  soqpsk_pkg::mode_t   mode,
	output soqpsk_pkg::phase_t  phase_out
);

	import soqpsk_pkg::*;

	logic [NCO_W-1:0] nco_d1;
	logic [NCO_W-1:0] nco_d2; // lines the ramp up with the held alpha
	alpha_t           alpha_hold;
	phase_t           roll;
	phase_t           step;
	phase_t           ramp;

	always_ff @(posedge clk)
	begin
		nco_d1 <= nco_phase;
		nco_d2 <= nco_d1;
	end

	assign ramp = phase_t'(nco_d2[NCO_W-1 -: RAMP_W]);

	// full swing of the symbol that just ended
	always_comb
	begin
		case (alpha_hold)
			ALPHA_POS: step = QUARTER_TURN;
			ALPHA_NEG: step = -QUARTER_TURN;
			default:   step = '0;
		endcase
	end

	//**********************************************************************
	// roll and output
	//**********************************************************************
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			roll       <= '0;
			alpha_hold <= ALPHA_ZERO;
			phase_out  <= '0;
		end
		else
		begin
			if (alpha_valid)
			begin
				roll       <= roll + step; // wraps mod 2pi by width
				alpha_hold <= alpha;
			end

			case (mode)
				MODE_SOQPSK:
				begin
					case (alpha_hold)
						ALPHA_POS: phase_out <= roll + ramp;
						ALPHA_NEG: phase_out <= roll - ramp;
						default:   phase_out <= roll;
					endcase
				end
				MODE_TEST: phase_out <= nco_d2[NCO_W-1 -: PHASE_W];
				default:   phase_out <= '0; // carrier only
			endcase
		end
	end

endmodule

// File: design/soqpsk_tx.sv
/*
 * SOQPSK baseband phase transmitter
 * NCO, bit intake, precoder and phase modulator in one pipeline
 */

`timescale 1ns/1ns

module soqpsk_tx
#(
	parameter int NCO_W = 32
)
(
	input  logic               clk,
	input  logic               rst,
	input  logic [NCO_W-1:0]   freq_word,
	input  soqpsk_pkg::mode_t  mode,
	input  logic               diff_en,
	input  logic               rand_en,
	input  logic               dat_pol,
	input  logic               src_req,
	input  logic               src_data,
	output logic               src_ack,
	output soqpsk_pkg::phase_t phase_out,
	output logic               sym_clk,
	output logic               underrun
);

	import soqpsk_pkg::*;

	logic [NCO_W-1:0] nco_phase;
	logic             sym_strobe;
	logic             tx_bit;
	logic             bit_valid;
	alpha_t           alpha;
	logic             alpha_valid;

	assign sym_clk = nco_phase[NCO_W-1]; // roughly square at symbol rate

	symbol_nco #(.NCO_W(NCO_W)) nco_i
	(
		.clk        (clk),
		.rst        (rst),
		.freq_word  (freq_word),
		.nco_phase  (nco_phase),
		.sym_strobe (sym_strobe)
	);

	bit_intake intake_i
	(
		.clk        (clk),
		.rst        (rst),
		.sym_strobe (sym_strobe),
		.src_req    (src_req),
		.src_data   (src_data),
		.dat_pol    (dat_pol),
		.rand_en    (rand_en),
		.src_ack    (src_ack),
		.tx_bit     (tx_bit),
		.bit_valid  (bit_valid),
		.underrun   (underrun)
	);

	soqpsk_precoder precoder_i
	(
		.clk         (clk),
		.rst         (rst),
		.tx_bit      (tx_bit),
		.bit_valid   (bit_valid),
		.diff_en     (diff_en),
		.alpha       (alpha),
		.alpha_valid (alpha_valid)
	);

	phase_modulator #(.NCO_W(NCO_W)) modulator_i
	(
		.clk         (clk),
		.rst         (rst),
		.nco_phase   (nco_phase),
		.alpha       (alpha),
		.alpha_valid (alpha_valid),
		.mode        (mode),
		.phase_out   (phase_out)
	);

endmodule

// File: tb/soqpsk_tx_tb.sv
/*
 * SOQPSK transmitter testbench
 * xorshift stimulus, cycle model of the pipeline, per-cycle output compare
 */

`timescale 1ns/1ns

module soqpsk_tx_tb;

	import soqpsk_pkg::*;

	localparam int NCO_W = 32;
	localparam logic [31:0] SEED = 32'h1558f14d;
	localparam int SYMS_LONG = 200;
	localparam int SYMS_SHORT = 40;
	localparam int TOTAL_SYMS = 8 * SYMS_LONG + 3 * SYMS_SHORT;
	localparam int CYCLE_LIMIT = TOTAL_SYMS * (1 << (NCO_W - 28)) + 200;

	logic clk;
	logic rst;
	logic [NCO_W-1:0] freq_word;
	mode_t mode;
	logic diff_en;
	logic rand_en;
	logic dat_pol;
	logic src_req = 1'b0;
	logic src_data = 1'b0;
	logic src_ack;
	phase_t phase_out;
	logic sym_clk;
	logic underrun;

	logic src_en;
	logic [31:0] cfg_rng;
	logic [31:0] src_rng = ~SEED; // own stream for the source
	int gap = 0;
	int cycles = 0;
	int err_count = 0;
	int accepts = 0;
	int underruns = 0;
	logic prev_ack = 1'b0;
	string test_name = "reset";

	// model state mirrors the DUT registers
	logic [NCO_W-1:0] m_nco = '0;
	logic [NCO_W-1:0] m_nco_d1 = '0;
	logic [NCO_W-1:0] m_nco_d2 = '0;
	logic m_strobe, m_ack, m_full, m_buf, m_tx, m_bv, m_under;
	logic [SCRAM_TAP_B-1:0] m_scr;
	logic m_flip, m_i0, m_i1, m_i2, m_q0, m_q1, m_q2, m_av;
	alpha_t m_alpha;
	alpha_t m_hold;
	phase_t m_roll;
	phase_t m_phase;

	soqpsk_tx #(.NCO_W(NCO_W)) dut_i
	(
		.clk       (clk),
		.rst       (rst),
		.freq_word (freq_word),
		.mode      (mode),
		.diff_en   (diff_en),
		.rand_en   (rand_en),
		.dat_pol   (dat_pol),
		.src_req   (src_req),
		.src_data  (src_data),
		.src_ack   (src_ack),
		.phase_out (phase_out),
		.sym_clk   (sym_clk),
		.underrun  (underrun)
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic fail_run(input string why);
		err_count++;
		$display("%s", why);
		$display("Checks failed");
		$fatal(1, "run stopped at first error");
	endtask

	//**********************************************************************
	// compare tasks
	//**********************************************************************
	task automatic check_phase(input phase_t exp, input phase_t act);
		if (exp !== act)
			fail_run($sformatf("MISMATCH %s phase_out: expected %0d actual %0d",
				test_name, exp, act));
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		if (exp !== act)
			fail_run($sformatf("MISMATCH %s %s: expected %b actual %b",
				test_name, what, exp, act));
	endtask

	task automatic check_alpha_free(input alpha_t exp, input alpha_t act);
		if (act != ALPHA_ZERO && act != ALPHA_POS && act != ALPHA_NEG)
			fail_run($sformatf("%s: precoder alpha holds an illegal code", test_name));
		if (exp !== act)
			fail_run($sformatf("MISMATCH %s alpha: expected %0d actual %0d",
				test_name, exp, act));
	endtask

	//**********************************************************************
	// cycle model updates stages back to front so each reads old state
	//**********************************************************************
	task automatic model_step();
		logic [NCO_W:0] sum;
		logic cap, raw, pol, sent, new_bit;
		phase_t ramp;
		phase_t test_phase;
		alpha_t next_alpha;
		ramp = phase_t'(m_nco_d2[NCO_W-1 -: RAMP_W]); // one symbol = quarter turn
		test_phase = m_nco_d2[NCO_W-1 -: PHASE_W]; // NCO three cycles back
		m_nco_d2 = m_nco_d1;
		m_nco_d1 = m_nco;
		if (rst)
		begin
			m_nco = '0;
			m_strobe = 1'b0;
			m_ack = 1'b0;
			m_full = 1'b0;
			m_scr = '0;
			m_bv = 1'b0;
			m_under = 1'b0;
			{m_flip, m_av} = 2'b00;
			{m_i0, m_i1, m_i2, m_q0, m_q1, m_q2} = 6'b111111;
			m_alpha = ALPHA_ZERO;
			m_hold = ALPHA_ZERO;
			m_roll = '0;
			m_phase = '0;
			return;
		end
		// phase out from the roll and alpha held before this edge
		case (mode)
			MODE_SOQPSK: m_phase = (m_hold == ALPHA_POS) ? m_roll + ramp :
				(m_hold == ALPHA_NEG) ? m_roll - ramp : m_roll;
			MODE_TEST: m_phase = test_phase;
			default: m_phase = '0;
		endcase
		if (m_av)
		begin
			if (m_hold == ALPHA_POS)
				m_roll = m_roll + QUARTER_TURN;
			else if (m_hold == ALPHA_NEG)
				m_roll = m_roll - QUARTER_TURN;
			m_hold = m_alpha;
		end
		// precoder
		m_av = m_bv;
		if (m_bv)
		begin
			next_alpha = ALPHA_ZERO;
			if (!m_flip && m_q0 != m_q2)
				next_alpha = (m_q0 == m_i1) ? ALPHA_POS : ALPHA_NEG;
			if (m_flip && m_i0 != m_i2)
				next_alpha = (m_i0 != m_q1) ? ALPHA_POS : ALPHA_NEG;
			m_alpha = next_alpha;
			if (!m_flip)
				new_bit = diff_en ? (m_tx ^ ~m_q0) : m_tx;
			else
				new_bit = diff_en ? (m_tx ^ m_i0) : m_tx;
			{m_i2, m_i1, m_q2, m_q1} = {m_i1, m_i0, m_q1, m_q0};
			if (!m_flip)
				m_i0 = new_bit;
			else
				m_q0 = new_bit;
			m_flip = ~m_flip;
		end
		// intake and scrambler
		cap = src_req & ~m_ack & ~m_full;
		raw = m_full ? m_buf : FILL_BIT;
		pol = raw ^ dat_pol;
		sent = rand_en ? (pol ^ m_scr[SCRAM_TAP_A-1] ^ m_scr[SCRAM_TAP_B-1]) : pol;
		m_bv = m_strobe;
		m_under = m_strobe & ~m_full;
		if (m_strobe)
		begin
			m_tx = sent;
			if (rand_en)
				m_scr = {m_scr[SCRAM_TAP_B-2:0], sent};
			m_full = 1'b0;
		end
		if (cap)
		begin
			m_ack = 1'b1;
			m_full = 1'b1;
			m_buf = src_data;
		end
		else if (!src_req)
			m_ack = 1'b0;
		// symbol NCO
		sum = {1'b0, m_nco} + {1'b0, freq_word};
		m_nco = sum[NCO_W-1:0];
		m_strobe = sum[NCO_W];
	endtask

	always @(posedge clk)
		model_step();

	// four-phase source with random idle gaps
	always @(posedge clk)
	begin
		if (rst || !src_en)
			src_req <= 1'b0;
		else if (src_req)
		begin
			if (src_ack)
				src_req <= 1'b0;
		end
		else if (!src_ack)
		begin
			if (gap > 0)
				gap <= gap - 1;
			else
			begin
				src_rng = xorshift(src_rng);
				src_data <= src_rng[7];
				src_req <= 1'b1;
				gap <= int'(src_rng % 32'd4);
			end
		end
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
			fail_run("timeout, the run went past its cycle limit");
	end

	always @(negedge clk)
	begin
		if (!rst)
		begin
			check_phase(m_phase, phase_out);
			check_bit("src_ack", m_ack, src_ack);
			check_bit("underrun", m_under, underrun);
			check_bit("sym_clk", m_nco[NCO_W-1], sym_clk);
			check_alpha_free(m_alpha, dut_i.precoder_i.alpha);
			if (src_ack && !prev_ack)
				accepts++;
			if (accepts > 1)
				fail_run("two source bits were accepted between symbol strobes");
			if (m_strobe)
				accepts = 0;
			if (underrun)
				underruns++;
			prev_ack = src_ack;
		end
	end

	task automatic run_symbols(input int n);
		for (int s = 0; s < n; s++)
		begin
			do
				@(negedge clk);
			while (!m_strobe);
		end
	endtask

	task automatic new_freq();
		cfg_rng = xorshift(cfg_rng);
		freq_word <= 32'h1000_0000 + (cfg_rng % 32'h3000_0000); // 2^28 .. 2^30
	endtask

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		freq_word = 32'h2000_0000;
		mode = MODE_SOQPSK;
		{diff_en, rand_en, dat_pol, src_en} = 4'b0000;
		cfg_rng = SEED;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_bit("src_ack after reset", 1'b0, src_ack);
		check_bit("underrun after reset", 1'b0, underrun);
		check_phase('0, phase_out);

		// every diff_en / rand_en / dat_pol combination
		for (int c = 0; c < 8; c++)
		begin
			@(posedge clk);
			{diff_en, rand_en, dat_pol} <= c[2:0];
			src_en <= 1'b1;
			new_freq();
			test_name = $sformatf("soqpsk diff%0d rand%0d pol%0d", c[2], c[1], c[0]);
			run_symbols(SYMS_LONG);
		end

		@(posedge clk);
		src_en <= 1'b0; // source withheld so only fill bits go out
		test_name = "underrun";
		underruns = 0;
		run_symbols(SYMS_SHORT);
		if (underruns == 0)
			fail_run("no underrun pulse while the source was withheld");

		@(posedge clk);
		src_en <= 1'b1;
		mode <= MODE_CARRIER;
		test_name = "carrier";
		run_symbols(SYMS_SHORT);

		@(posedge clk);
		mode <= MODE_TEST;
		new_freq();
		test_name = "nco test";
		run_symbols(SYMS_SHORT);

		if (err_count == 0)
		begin
			$display("All checks passed");
			$finish;
		end
		else
		begin
			$display("Checks failed");
			$fatal(1, "errors were recorded");
		end
	end

endmodule

// File: vlog.f
design/soqpsk_pkg.sv
design/symbol_nco.sv
design/bit_intake.sv
design/soqpsk_precoder.sv
design/phase_modulator.sv
design/soqpsk_tx.sv
tb/soqpsk_tx_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the SOQPSK transmitter testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f vlog.f --top-module soqpsk_tx_tb -o soqpsk_tx_sim; then
	echo "verilator build failed"
	exit 1
fi

if ! ./obj_dir/soqpsk_tx_sim; then
	echo "simulation returned a failing status"
	exit 1
fi

echo "simulation completed"
exit 0
